/* bench/sv32_input.txt */
# M addr data = memory preload, E addr = word answered with error, all fields hex
# T priv satp mxr sum addr wen wdata kind(0 ok,1 access,2 page) rdata wb wb_addr wb_data accesses
M 00010004 00004401
M 00010008 001000c7
M 0001000c 001004c7
M 00011004 000080c7
M 00011008 00008443
M 0001100c 000088d7
M 00011010 00008c49
M 00011014 00009007
M 0001101c 000094c7
M 00020234 cafe0001
M 00021010 11110010
M 00022004 22220004
M 00023008 33330008
M 00024000 44440000
M 00403458 0badf00d
E 00011018
E 00025000
T 3 80000010 0 0 00020234 0 00000000 0 cafe0001 0 00000000 00000000 1
T 3 80000010 0 0 00003000 1 12345678 0 00000000 0 00000000 00000000 1
T 1 00000010 0 0 00003000 0 00000000 0 12345678 0 00000000 00000000 1
T 1 80000010 0 0 00401234 0 00000000 0 cafe0001 0 00000000 00000000 3
T 1 80000010 0 0 00401238 1 a5a50001 0 00000000 0 00000000 00000000 3
T 1 80000010 0 0 00401238 0 00000000 0 a5a50001 0 00000000 00000000 3
T 1 80000010 0 0 00803458 0 00000000 0 0badf00d 0 00000000 00000000 2
T 1 80000010 0 0 00c00000 0 00000000 2 00000000 0 00000000 00000000 1
T 1 80000010 0 0 00402000 1 deadbeef 2 00000000 0 00000000 00000000 2
T 1 80000010 0 0 00402010 0 00000000 0 11110010 0 00000000 00000000 3
T 1 80000010 0 0 00403004 0 00000000 2 00000000 0 00000000 00000000 2
T 1 80000010 0 1 00403004 0 00000000 0 22220004 0 00000000 00000000 3
T 0 80000010 0 0 00401234 0 00000000 2 00000000 0 00000000 00000000 2
T 0 80000010 0 0 00403004 0 00000000 0 22220004 0 00000000 00000000 3
T 1 80000010 0 0 00404008 0 00000000 2 00000000 0 00000000 00000000 2
T 1 80000010 1 0 00404008 0 00000000 0 33330008 0 00000000 00000000 3
T 1 80000010 0 0 00405000 0 00000000 0 44440000 1 00011014 00009047 4
T 1 80000010 0 0 00405004 1 55550004 0 00000000 1 00011014 000090c7 4
T 1 80000010 0 0 00405004 0 00000000 0 55550004 0 00000000 00000000 3
T 1 80000010 0 0 00406000 0 00000000 1 00000000 0 00000000 00000000 2
T 1 80000010 0 0 00407000 0 00000000 1 00000000 0 00000000 00000000 3

/* project.f */
common/sv32_pkg.sv
page_walker/pte_check.sv
page_walker/page_walker.sv
verilog/mem_port_mux.sv
verilog/sv32_mmu_top.sv
bench/sv32_mem_model.sv
bench/sv32_mmu_tb.sv

/* Makefile */
SIM  := obj_dir/Vsv32_mmu_tb
SRCS := $(shell grep '\.sv$$' project.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) project.f
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module sv32_mmu_tb -f project.f

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir

/* bench/sv32_mmu_tb.sv */
`timescale 1ns/100ps

module sv32_mmu_tb;

    localparam int    TIMEOUT_CYCLES = 100;
    localparam string INPUT_FILE     = "bench/sv32_input.txt";

    logic               clk;
    logic               reset;
    logic               req_valid;
    logic               req_ready;
    sv32_pkg::vaddr_t   req_addr;
    logic               req_wen;
    sv32_pkg::word_t    req_wdata;
    sv32_pkg::wmask_t   req_wmask;
    logic               resp_valid;
    sv32_pkg::word_t    resp_rdata;
    logic               resp_error;
    sv32_pkg::fault_t   resp_fault;
    sv32_pkg::priv_t    priv;
    sv32_pkg::satp_t    satp;
    logic               mxr;
    logic               sum;
    logic               mem_valid;
    logic               mem_ready;
    sv32_pkg::paddr_t   mem_addr;
    logic               mem_wen;
    sv32_pkg::word_t    mem_wdata;
    sv32_pkg::wmask_t   mem_wmask;
    logic               mem_resp_valid;
    sv32_pkg::word_t    mem_resp_rdata;
    logic               mem_resp_error;
    int                 access_count;
    int                 write_count;
    sv32_pkg::paddr_t   last_write_addr;
    sv32_pkg::word_t    last_write_data;

    int                 fd;
    int                 n_tests;
    string              line;
    logic [31:0]        t_priv;
    logic [31:0]        t_satp;
    logic [31:0]        t_mxr;
    logic [31:0]        t_sum;
    logic [31:0]        t_addr;
    logic [31:0]        t_wen;
    logic [31:0]        t_wdata;
    logic [31:0]        t_kind;
    logic [31:0]        t_rdata;
    logic [31:0]        t_wb;
    logic [31:0]        t_wb_addr;
    logic [31:0]        t_wb_data;
    logic [31:0]        t_acc;

    sv32_mmu_top UUT (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req_addr(req_addr),
        .req_wen(req_wen), .req_wdata(req_wdata), .req_wmask(req_wmask),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .resp_error(resp_error), .resp_fault(resp_fault),
        .priv(priv), .satp(satp), .mxr(mxr), .sum(sum),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata),
        .mem_resp_error(mem_resp_error)
    );

    sv32_mem_model u_memory (
        .clk(clk), .reset(reset),
        .mem_valid(mem_valid), .mem_ready(mem_ready), .mem_addr(mem_addr),
        .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
        .mem_resp_valid(mem_resp_valid), .mem_resp_rdata(mem_resp_rdata),
        .mem_resp_error(mem_resp_error),
        .access_count(access_count), .write_count(write_count),
        .last_write_addr(last_write_addr), .last_write_data(last_write_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input sv32_pkg::word_t exp, input sv32_pkg::word_t got);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: resp_rdata expected %h got %h",
                                     $time, exp, got));
        end
    endtask

    task automatic check_fault(input sv32_pkg::fault_t exp, input sv32_pkg::fault_t got);
        if (got !== exp) begin
            report_failure($sformatf("MISMATCH at %0t: resp_fault expected %s got %s",
                                     $time, exp.name(), got.name()));
        end
    endtask

    task automatic check_writeback(input sv32_pkg::paddr_t exp_addr,
                                   input sv32_pkg::pte_t exp_pte);
        if (last_write_addr !== exp_addr) begin
            report_failure($sformatf("MISMATCH at %0t: write-back mem_addr expected %h got %h",
                                     $time, exp_addr, last_write_addr));
        end
        if (sv32_pkg::pte_t'(last_write_data) !== exp_pte) begin
            report_failure($sformatf("MISMATCH at %0t: write-back mem_wdata expected %h got %h",
                                     $time, exp_pte, last_write_data));
        end
    endtask

    // sampled on the falling edge, away from the input updates
    task automatic wait_request_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!req_ready) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("timeout while waiting for req_ready");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_response(output sv32_pkg::word_t rdata, output logic error,
                                 output sv32_pkg::fault_t fault);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!resp_valid) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                report_failure("timeout while waiting for resp_valid");
            end
            @(negedge clk);
            cycles++;
        end
        rdata = resp_rdata;
        error = resp_error;
        fault = resp_fault;
    endtask

    task automatic run_transaction();
        int               base_acc;
        int               base_wr;
        int               exp_wr;
        sv32_pkg::word_t  got_rdata;
        logic             got_error;
        sv32_pkg::fault_t got_fault;
        sv32_pkg::fault_t exp_fault;
        base_acc  = access_count;
        base_wr   = write_count;
        exp_fault = (t_kind == 2) ? sv32_pkg::PAGE_FAULT : sv32_pkg::ACCESS_FAULT;
        @(posedge clk);
        priv      <= sv32_pkg::priv_t'(t_priv[1:0]);
        satp      <= t_satp;
        mxr       <= t_mxr[0];
        sum       <= t_sum[0];
        req_valid <= 1'b1;
        req_addr  <= t_addr;
        req_wen   <= t_wen[0];
        req_wdata <= t_wdata;
        req_wmask <= 4'hf;
        wait_request_ready();
        @(posedge clk);
        req_valid <= 1'b0;
        wait_response(got_rdata, got_error, got_fault);
        // walker is idle again once any write-back has been answered
        wait_request_ready();
        if (t_kind == 0) begin
            if (got_error) begin
                report_failure($sformatf("unexpected error response for address %h", t_addr));
            end
            if (t_wen == 0) begin
                check_data(t_rdata, got_rdata);
            end
        end else begin
            if (!got_error) begin
                report_failure($sformatf("no fault reported for address %h", t_addr));
            end
            check_fault(exp_fault, got_fault);
        end
        exp_wr = 0;
        if (t_kind == 0 && t_wen != 0) begin
            exp_wr = exp_wr + 1;
        end
        if (t_wb != 0) begin
            exp_wr = exp_wr + 1;
        end
        if (write_count - base_wr != exp_wr) begin
            report_failure($sformatf("MISMATCH at %0t: write_count expected %0d got %0d",
                                     $time, exp_wr, write_count - base_wr));
        end
        if (t_wb != 0) begin
            check_writeback(t_wb_addr, t_wb_data);
        end
        if (access_count - base_acc != int'(t_acc)) begin
            report_failure($sformatf("MISMATCH at %0t: access_count expected %0d got %0d",
                                     $time, t_acc, access_count - base_acc));
        end
    endtask

    initial begin
        void'($urandom(32'hdecc_f498));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_wen   = 1'b0;
        req_wdata = '0;
        req_wmask = '0;
        priv      = sv32_pkg::M_MODE;
        satp      = '0;
        mxr       = 1'b0;
        sum       = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        n_tests = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            report_failure("cannot open the stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "T %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_priv, t_satp, t_mxr, t_sum, t_addr, t_wen, t_wdata,
                        t_kind, t_rdata, t_wb, t_wb_addr, t_wb_data, t_acc) == 13) begin
                run_transaction();
                n_tests++;
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            report_failure("no transactions found in the stimulus file");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* bench/sv32_mem_model.sv */
`timescale 1ns/100ps

module sv32_mem_model (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_valid,
    output logic                mem_ready,
    input  sv32_pkg::paddr_t    mem_addr,
    input  logic                mem_wen,
    input  sv32_pkg::word_t     mem_wdata,
    input  sv32_pkg::wmask_t    mem_wmask,
    output logic                mem_resp_valid,
    output sv32_pkg::word_t     mem_resp_rdata,
    output logic                mem_resp_error,
    // running totals for the bench
    output int                  access_count,
    output int                  write_count,
    output sv32_pkg::paddr_t    last_write_addr,
    output sv32_pkg::word_t     last_write_data
);

    localparam string INPUT_FILE = "bench/sv32_input.txt";

    sv32_pkg::word_t    mem [sv32_pkg::paddr_t];
    bit                 err_map [sv32_pkg::paddr_t];
    logic               busy;
    logic [1:0]         wait_cnt;
    sv32_pkg::paddr_t   pend_addr;
    logic               pend_wen;
    int                 fd;
    string              line;
    logic [31:0]        f_addr;
    logic [31:0]        f_data;

    function automatic sv32_pkg::paddr_t word_addr(input sv32_pkg::paddr_t a);
        return {a[31:2], 2'b00};
    endfunction

    // words never loaded read back as a pattern of their own address
    function automatic sv32_pkg::word_t read_word(input sv32_pkg::paddr_t a);
        sv32_pkg::paddr_t wa;
        wa = word_addr(a);
        if (mem.exists(wa) != 0) begin
            return mem[wa];
        end
        return wa ^ 32'h5ee5_a11a;
    endfunction

    function automatic sv32_pkg::word_t merge_bytes(input sv32_pkg::word_t old,
                                                   input sv32_pkg::word_t wdata,
                                                   input sv32_pkg::wmask_t m);
        sv32_pkg::word_t r;
        int i;
        r = old;
        for (i = 0; i < 4; i++) begin
            if (m[i]) begin
                r[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return r;
    endfunction

    // preload words and error addresses from the M and E lines
    initial begin
        fd = $fopen(INPUT_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "M %h %h", f_addr, f_data) == 2) begin
                    mem[word_addr(f_addr)] = f_data;
                end else if ($sscanf(line, "E %h", f_addr) == 1) begin
                    err_map[word_addr(f_addr)] = 1'b1;
                end
            end
            $fclose(fd);
        end
    end

    assign mem_ready = !busy;

    always @(posedge clk) begin
        mem_resp_valid <= 1'b0;
        if (reset) begin
            busy            <= 1'b0;
            wait_cnt        <= 2'd0;
            pend_addr       <= '0;
            pend_wen        <= 1'b0;
            mem_resp_rdata  <= '0;
            mem_resp_error  <= 1'b0;
            access_count    <= 0;
            write_count     <= 0;
            last_write_addr <= '0;
            last_write_data <= '0;
        end else if (!busy) begin
            if (mem_valid) begin
                busy         <= 1'b1;
                // answer 1 to 4 cycles later
                wait_cnt     <= 2'($urandom % 4);
                pend_addr    <= word_addr(mem_addr);
                pend_wen     <= mem_wen;
                access_count <= access_count + 1;
                if (mem_wen) begin
                    mem[word_addr(mem_addr)] = merge_bytes(read_word(mem_addr), mem_wdata,
                                                           mem_wmask);
                    write_count     <= write_count + 1;
                    last_write_addr <= mem_addr;
                    last_write_data <= mem_wdata;
                end
            end
        end else if (wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end else begin
            busy           <= 1'b0;
            mem_resp_valid <= 1'b1;
            mem_resp_rdata <= pend_wen ? '0 : read_word(pend_addr);
            mem_resp_error <= err_map.exists(pend_addr) != 0;
        end
    end

endmodule

/* verilog/sv32_mmu_top.sv */
`timescale 1ns/100ps

module sv32_mmu_top (
    input  logic                clk,
    input  logic                reset,
    // core side
    input  logic                req_valid,
    output logic                req_ready,
    input  sv32_pkg::vaddr_t    req_addr,
    input  logic                req_wen,
    input  sv32_pkg::word_t     req_wdata,
    input  sv32_pkg::wmask_t    req_wmask,
    output logic                resp_valid,
    output sv32_pkg::word_t     resp_rdata,
    output logic                resp_error,
    output sv32_pkg::fault_t    resp_fault,
    input  sv32_pkg::priv_t     priv,
    input  sv32_pkg::satp_t     satp,
    input  logic                mxr,
    input  logic                sum,
    // memory side
    output logic                mem_valid,
    input  logic                mem_ready,
    output sv32_pkg::paddr_t    mem_addr,
    output logic                mem_wen,
    output sv32_pkg::word_t     mem_wdata,
    output sv32_pkg::wmask_t    mem_wmask,
    input  logic                mem_resp_valid,
    input  sv32_pkg::word_t     mem_resp_rdata,
    input  logic                mem_resp_error
);

    logic               pte_valid;
    logic               pte_ready;
    sv32_pkg::paddr_t   pte_addr;
    logic               pte_wen;
    sv32_pkg::pte_t     pte_wdata;
    logic               data_valid;
    logic               data_ready;
    sv32_pkg::paddr_t   data_addr;
    logic               data_wen;
    sv32_pkg::word_t    data_wdata;
    sv32_pkg::wmask_t   data_wmask;
    logic               pte_resp_valid;
    logic               data_resp_valid;

    page_walker u_page_walker (
        .clk             (clk),
        .reset           (reset),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_addr        (req_addr),
        .req_wen         (req_wen),
        .req_wdata       (req_wdata),
        .req_wmask       (req_wmask),
        .resp_valid      (resp_valid),
        .resp_rdata      (resp_rdata),
        .resp_error      (resp_error),
        .resp_fault      (resp_fault),
        .priv            (priv),
        .satp            (satp),
        .mxr             (mxr),
        .sum             (sum),
        .pte_valid       (pte_valid),
        .pte_ready       (pte_ready),
        .pte_addr        (pte_addr),
        .pte_wen         (pte_wen),
        .pte_wdata       (pte_wdata),
        .data_valid      (data_valid),
        .data_ready      (data_ready),
        .data_addr       (data_addr),
        .data_wen        (data_wen),
        .data_wdata      (data_wdata),
        .data_wmask      (data_wmask),
        .pte_resp_valid  (pte_resp_valid),
        .data_resp_valid (data_resp_valid),
        .mem_rdata       (mem_resp_rdata),
        .mem_error       (mem_resp_error)
    );

    // single port shared by walks, data and write-backs
    mem_port_mux u_mem_port_mux (
        .clk             (clk),
        .reset           (reset),
        .pte_valid       (pte_valid),
        .pte_ready       (pte_ready),
        .pte_addr        (pte_addr),
        .pte_wen         (pte_wen),
        .pte_wdata       (pte_wdata),
        .data_valid      (data_valid),
        .data_ready      (data_ready),
        .data_addr       (data_addr),
        .data_wen        (data_wen),
        .data_wdata      (data_wdata),
        .data_wmask      (data_wmask),
        .pte_resp_valid  (pte_resp_valid),
        .data_resp_valid (data_resp_valid),
        .mem_valid       (mem_valid),
        .mem_ready       (mem_ready),
        .mem_addr        (mem_addr),
        .mem_wen         (mem_wen),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_resp_valid  (mem_resp_valid)
    );

endmodule

/* verilog/mem_port_mux.sv */
`timescale 1ns/100ps

module mem_port_mux (
    input  logic                clk,
    input  logic                reset,
    input  logic                pte_valid,
    output logic                pte_ready,
    input  sv32_pkg::paddr_t    pte_addr,
    input  logic                pte_wen,
    input  sv32_pkg::pte_t      pte_wdata,
    input  logic                data_valid,
    output logic                data_ready,
    input  sv32_pkg::paddr_t    data_addr,
    input  logic                data_wen,
    input  sv32_pkg::word_t     data_wdata,
    input  sv32_pkg::wmask_t    data_wmask,
    output logic                pte_resp_valid,
    output logic                data_resp_valid,
    output logic                mem_valid,
    input  logic                mem_ready,
    output sv32_pkg::paddr_t    mem_addr,
    output logic                mem_wen,
    output sv32_pkg::word_t     mem_wdata,
    output sv32_pkg::wmask_t    mem_wmask,
    input  logic                mem_resp_valid
);

    logic busy;
    // set when the pte side owns the outstanding request
    logic owner_pte;

    assign mem_valid = !busy && (pte_valid || data_valid);
    assign mem_addr  = pte_valid ? pte_addr  : data_addr;
    assign mem_wen   = pte_valid ? pte_wen   : data_wen;
    assign mem_wdata = pte_valid ? pte_wdata : data_wdata;
    // pte write-backs always cover the whole word
    assign mem_wmask = pte_valid ? 4'hf : data_wmask;

    assign pte_ready  = !busy && mem_ready;
    assign data_ready = !busy && mem_ready;

    assign pte_resp_valid  = mem_resp_valid && busy && owner_pte;
    assign data_resp_valid = mem_resp_valid && busy && !owner_pte;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_pte <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            busy      <= 1'b1;
            owner_pte <= pte_valid;
        end else if (mem_resp_valid) begin
            busy <= 1'b0;
        end
    end

    // walker never raises pte and data requests together
    a_one_requester: assert property (@(posedge clk) disable iff (reset)
        !(pte_valid && data_valid));

    // memory only answers what was accepted
    a_resp_needs_req: assert property (@(posedge clk) disable iff (reset)
        mem_resp_valid |-> busy);

endmodule

/* page_walker/page_walker.sv */
`timescale 1ns/100ps

module page_walker (
    input  logic                clk,
    input  logic                reset,
    // core request
    input  logic                req_valid,
    output logic                req_ready,
    input  sv32_pkg::vaddr_t    req_addr,
    input  logic                req_wen,
    input  sv32_pkg::word_t     req_wdata,
    input  sv32_pkg::wmask_t    req_wmask,
    // core response
    output logic                resp_valid,
    output sv32_pkg::word_t     resp_rdata,
    output logic                resp_error,
    output sv32_pkg::fault_t    resp_fault,
    input  sv32_pkg::priv_t     priv,
    input  sv32_pkg::satp_t     satp,
    input  logic                mxr,
    input  logic                sum,
    // toward the port mux
    output logic                pte_valid,
    input  logic                pte_ready,
    output sv32_pkg::paddr_t    pte_addr,
    output logic                pte_wen,
    output sv32_pkg::pte_t      pte_wdata,
    output logic                data_valid,
    input  logic                data_ready,
    output sv32_pkg::paddr_t    data_addr,
    output logic                data_wen,
    output sv32_pkg::word_t     data_wdata,
    output sv32_pkg::wmask_t    data_wmask,
    input  logic                pte_resp_valid,
    input  logic                data_resp_valid,
    input  sv32_pkg::word_t     mem_rdata,
    input  logic                mem_error
);

    typedef enum logic [2:0] {
        IDLE,
        PTE_REQ,
        PTE_WAIT,
        DATA_REQ,
        DATA_WAIT,
        RESP,
        AD_REQ,
        AD_WAIT
    } state_t;

    localparam int VPN0_LSB = sv32_pkg::PAGE_OFFSET_BITS;
    localparam int VPN1_LSB = sv32_pkg::PAGE_OFFSET_BITS + sv32_pkg::VPN_BITS;
    localparam int FULL_BITS = sv32_pkg::PPN_BITS + sv32_pkg::PAGE_OFFSET_BITS;

    state_t             state;
    logic               translate;
    sv32_pkg::vaddr_t   s_addr;
    logic               s_wen;
    sv32_pkg::word_t    s_wdata;
    sv32_pkg::wmask_t   s_wmask;
    logic               level;
    sv32_pkg::paddr_t   walk_addr;
    sv32_pkg::pte_t     leaf_pte;
    sv32_pkg::paddr_t   phys_addr;
    sv32_pkg::word_t    result_rdata;
    logic               result_error;
    sv32_pkg::fault_t   result_fault;
    sv32_pkg::pte_t     cur_pte;
    logic               is_leaf;
    logic               page_fault;
    logic               need_ad;
    logic [FULL_BITS-1:0] next_table;
    logic [FULL_BITS-1:0] leaf_addr;

    assign translate = priv != sv32_pkg::M_MODE && satp[sv32_pkg::SATP_MODE_BIT];
    assign cur_pte   = sv32_pkg::pte_t'(mem_rdata);

    pte_check u_pte_check (
        .pte        (cur_pte),
        .level      (level),
        .is_store   (s_wen),
        .priv       (priv),
        .mxr        (mxr),
        .sum        (sum),
        .is_leaf    (is_leaf),
        .page_fault (page_fault)
    );

    // next table entry at ppn*4096 + vpn0*4
    assign next_table = {cur_pte[31:sv32_pkg::PTE_PPN_LSB], s_addr[VPN0_LSB +: sv32_pkg::VPN_BITS],
                         {sv32_pkg::PTE_SIZE_LOG2{1'b0}}};
    // megapage keeps vpn0 from the virtual address
    assign leaf_addr = level ?
        {cur_pte[31:20], s_addr[VPN0_LSB +: sv32_pkg::VPN_BITS], s_addr[VPN0_LSB-1:0]} :
        {cur_pte[31:sv32_pkg::PTE_PPN_LSB], s_addr[VPN0_LSB-1:0]};

    assign need_ad = !leaf_pte[sv32_pkg::PTE_A] || (s_wen && !leaf_pte[sv32_pkg::PTE_D]);

    // bare mode goes straight to the data side of the mux
    assign req_ready  = translate ? state == IDLE : data_ready;
    assign resp_valid = translate ? state == RESP : data_resp_valid;
    assign resp_rdata = translate ? result_rdata  : mem_rdata;
    assign resp_error = translate ? result_error  : mem_error;
    assign resp_fault = translate ? result_fault  : sv32_pkg::ACCESS_FAULT;

    assign data_valid = translate ? state == DATA_REQ : req_valid;
    assign data_addr  = translate ? phys_addr : req_addr;
    assign data_wen   = translate ? s_wen     : req_wen;
    assign data_wdata = translate ? s_wdata   : req_wdata;
    assign data_wmask = translate ? s_wmask   : req_wmask;

    // walk_addr still points at the leaf pte during write-back
    assign pte_valid = state == PTE_REQ || state == AD_REQ;
    assign pte_addr  = walk_addr;
    assign pte_wen   = state == AD_REQ;
    assign pte_wdata = leaf_pte | (sv32_pkg::pte_t'(1) << sv32_pkg::PTE_A)
                     | (sv32_pkg::pte_t'(s_wen) << sv32_pkg::PTE_D);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (translate && req_valid) begin
                        state <= PTE_REQ;
                        level <= 1'b1;
                        // root ppn*4096 + vpn1*4
                        walk_addr <= sv32_pkg::paddr_t'({satp[sv32_pkg::PPN_BITS-1:0],
                            req_addr[VPN1_LSB +: sv32_pkg::VPN_BITS],
                            {sv32_pkg::PTE_SIZE_LOG2{1'b0}}});
                    end
                end
                PTE_REQ: begin
                    if (pte_ready) begin
                        state <= PTE_WAIT;
                    end
                end
                PTE_WAIT: begin
                    if (pte_resp_valid) begin
                        if (mem_error || page_fault) begin
                            state        <= RESP;
                            result_error <= 1'b1;
                            result_fault <= mem_error ? sv32_pkg::ACCESS_FAULT
                                                      : sv32_pkg::PAGE_FAULT;
                        end else if (is_leaf) begin
                            state     <= DATA_REQ;
                            leaf_pte  <= cur_pte;
                            phys_addr <= leaf_addr[31:0];
                        end else begin
                            state     <= PTE_REQ;
                            level     <= 1'b0;
                            walk_addr <= next_table[31:0];
                        end
                    end
                end
                DATA_REQ: begin
                    if (data_ready) begin
                        state <= DATA_WAIT;
                    end
                end
                DATA_WAIT: begin
                    if (data_resp_valid) begin
                        state        <= RESP;
                        result_rdata <= mem_rdata;
                        result_error <= mem_error;
                        result_fault <= sv32_pkg::ACCESS_FAULT;
                    end
                end
                RESP: begin
                    state <= (!result_error && need_ad) ? AD_REQ : IDLE;
                end
                AD_REQ: begin
                    if (pte_ready) begin
                        state <= AD_WAIT;
                    end
                end
                AD_WAIT: begin
                    // idle only once the write-back is answered
                    if (pte_resp_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // the payload side is loaded on acceptance only
    always_ff @(posedge clk) begin
        if (state == IDLE && translate && req_valid) begin
            s_addr  <= req_addr;
            s_wen   <= req_wen;
            s_wdata <= req_wdata;
            s_wmask <= req_wmask;
        end
    end

    // no new request accepted while a walk is in progress
    a_busy_after_accept: assert property (@(posedge clk) disable iff (reset)
        state != IDLE |-> !req_ready);

    // responses are single pulses, in both modes
    a_resp_pulse: assert property (@(posedge clk) disable iff (reset)
        resp_valid |=> !resp_valid);

endmodule

/* page_walker/pte_check.sv */
`timescale 1ns/100ps

module pte_check (
    input  sv32_pkg::pte_t  pte,
    input  logic            level,
    input  logic            is_store,
    input  sv32_pkg::priv_t priv,
    input  logic            mxr,
    input  logic            sum,
    output logic            is_leaf,
    output logic            page_fault
);

    logic v;
    logic r;
    logic w;
    logic x;
    logic u;
    logic g;
    logic a;
    logic d;
    sv32_pkg::vpn_t ppn0;

    assign v    = pte[sv32_pkg::PTE_V];
    assign r    = pte[sv32_pkg::PTE_R];
    assign w    = pte[sv32_pkg::PTE_W];
    assign x    = pte[sv32_pkg::PTE_X];
    assign u    = pte[sv32_pkg::PTE_U];
    assign g    = pte[sv32_pkg::PTE_G];
    assign a    = pte[sv32_pkg::PTE_A];
    assign d    = pte[sv32_pkg::PTE_D];
    assign ppn0 = pte[sv32_pkg::PTE_PPN_LSB +: sv32_pkg::VPN_BITS];

    // x=w=r=0 means pointer to the next table
    assign is_leaf = r | w | x;

    always_comb begin
        page_fault = 1'b0;
        // invalid, reserved or global encodings
        if (!v || (w && !r) || g) begin
            page_fault = 1'b1;
        end
        // a/d/u are reserved on pointers, and level 0 has no next table
        if (!is_leaf && (a || d || u || !level)) begin
            page_fault = 1'b1;
        end
        if (is_leaf) begin
            // privilege vs user bit
            if (priv == sv32_pkg::S_MODE && u && !sum) begin
                page_fault = 1'b1;
            end
            if (priv == sv32_pkg::U_MODE && !u) begin
                page_fault = 1'b1;
            end
            // access type vs permission bits
            if (is_store && !w) begin
                page_fault = 1'b1;
            end
            if (!is_store && !r && !(mxr && x)) begin
                page_fault = 1'b1;
            end
            // misaligned megapage
            if (level && ppn0 != '0) begin
                page_fault = 1'b1;
            end
        end
    end

endmodule

/* common/sv32_pkg.sv */
package sv32_pkg;

    // sv32 field widths
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int VPN_BITS         = 10;
    localparam int PPN_BITS         = 22;
    localparam int PTE_SIZE_LOG2    = 2;

    // satp layout is mode(1) | asid(9) | ppn(22)
    localparam int SATP_MODE_BIT = 31;

    // pte flag positions
    localparam int PTE_V       = 0;
    localparam int PTE_R       = 1;
    localparam int PTE_W       = 2;
    localparam int PTE_X       = 3;
    localparam int PTE_U       = 4;
    localparam int PTE_G       = 5;
    localparam int PTE_A       = 6;
    localparam int PTE_D       = 7;
    // ppn starts above the rsw field
    localparam int PTE_PPN_LSB = 10;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;
    typedef logic [31:0] pte_t;
    typedef logic [31:0] satp_t;

    typedef logic [PPN_BITS-1:0] ppn_t;
    typedef logic [VPN_BITS-1:0] vpn_t;

    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_t;

    typedef enum logic {
        ACCESS_FAULT = 1'b0,
        PAGE_FAULT   = 1'b1
    } fault_t;

endpackage
